// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP       ?= tama_display_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
RUN_FLAGS ?= +verilator+error+limit+100

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== filelist.f ====
+incdir+include
hdl/wb_bus_pkg.sv
hdl/lcd_pkg.sv
hdl/clk_enable_gen.sv
hdl/program_rom.sv
hdl/lcd_segment_ram.sv
hdl/lcd_scanout.sv
hdl/tama_display_top.sv
verification/tama_display_checker.sv
verification/tama_display_tb.sv

// ==== hdl/clk_enable_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_macros.svh"

module clk_enable_gen (
  input  logic clk,
  input  logic arst_n,
  output logic clk_en_slow,
  output logic clk_en_fast
);

  localparam int unsigned DIV_W = $clog2(`LCD_DIV_RELOAD + 1);

  logic [DIV_W-1:0] div_cnt;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      div_cnt     <= DIV_W'(`LCD_DIV_RELOAD);
      clk_en_slow <= 1'b0;
      clk_en_fast <= 1'b0;
    end else begin
      clk_en_slow <= 1'b0;
      clk_en_fast <= 1'b0;
      if (div_cnt == '0) begin
        div_cnt     <= DIV_W'(`LCD_DIV_RELOAD);
        clk_en_slow <= 1'b1;
        clk_en_fast <= 1'b1; // both strobes share the zero point.
      end else begin
        div_cnt <= div_cnt - 1'b1;
        if (div_cnt == DIV_W'(`LCD_DIV_HALF)) begin
          clk_en_fast <= 1'b1; // mid period.
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

  localparam int LCD_WIDTH   = 32;
  localparam int LCD_HEIGHT  = 16;
  localparam int LCD_NIBBLES = LCD_WIDTH * LCD_HEIGHT / 4;

  // dot (x, y) sits in nibble y*8 + x/4, at bit x%4.
  typedef logic [$clog2(LCD_NIBBLES)-1:0] seg_addr_t;

  typedef logic [23:0] rgb_t;

  localparam rgb_t DOT_ON_RGB  = 24'h202020; // dark segment.
  localparam rgb_t DOT_OFF_RGB = 24'hc0d0a0; // lcd background.

endpackage

`default_nettype wire

// ==== hdl/lcd_scanout.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_macros.svh"

module lcd_scanout (
  input  logic               clk,
  input  logic               arst_n,
  output lcd_pkg::seg_addr_t video_addr,
  input  logic [3:0]         video_data,
  input  logic               lcd_all_off,
  input  logic               lcd_all_on,
  output logic               hsync,
  output logic               vsync,
  output logic               de,
  output lcd_pkg::rgb_t      rgb
);

  import lcd_pkg::*;

  localparam int unsigned H_W = $clog2(`LCD_H_TOTAL);
  localparam int unsigned V_W = $clog2(`LCD_V_TOTAL);

  localparam int unsigned H_SYNC_START = `LCD_H_ACTIVE + `LCD_H_FRONT;
  localparam int unsigned H_SYNC_END   = H_SYNC_START + `LCD_H_SYNC;
  localparam int unsigned V_SYNC_START = `LCD_V_ACTIVE + `LCD_V_FRONT;
  localparam int unsigned V_SYNC_END   = V_SYNC_START + `LCD_V_SYNC;

  logic [H_W-1:0] h_cnt;
  logic [V_W-1:0] v_cnt;
  logic           active;
  logic           hs_raw;
  logic           vs_raw;

  // stage 1, waiting on the ram read.
  logic           act_d1;
  logic           hs_d1;
  logic           vs_d1;
  logic [1:0]     bit_d1;
  logic           dot_on;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (h_cnt == H_W'(`LCD_H_TOTAL - 1)) begin
      h_cnt <= '0;
      v_cnt <= (v_cnt == V_W'(`LCD_V_TOTAL - 1)) ? '0 : v_cnt + 1'b1;
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign active = (h_cnt < H_W'(`LCD_H_ACTIVE)) && (v_cnt < V_W'(`LCD_V_ACTIVE));
  assign hs_raw = (h_cnt >= H_W'(H_SYNC_START)) && (h_cnt < H_W'(H_SYNC_END));
  assign vs_raw = (v_cnt >= V_W'(V_SYNC_START)) && (v_cnt < V_W'(V_SYNC_END));

  // row * 8 + x / 4.
  assign video_addr = seg_addr_t'((v_cnt * (`LCD_H_ACTIVE / 4)) + (h_cnt >> 2));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      act_d1 <= 1'b0;
      hs_d1  <= 1'b0;
      vs_d1  <= 1'b0;
    end else begin
      act_d1 <= active;
      hs_d1  <= hs_raw;
      vs_d1  <= vs_raw;
    end
  end

  always_ff @(posedge clk) begin
    bit_d1 <= h_cnt[1:0];
  end

  // all_off wins over all_on.
  assign dot_on = lcd_all_off ? 1'b0 : (lcd_all_on | video_data[bit_d1]);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      de    <= 1'b0;
      hsync <= 1'b0;
      vsync <= 1'b0;
      rgb   <= '0;
    end else begin
      de    <= act_d1;
      hsync <= hs_d1;
      vsync <= vs_d1;
      if (!act_d1) begin
        rgb <= '0; // blank outside the panel.
      end else begin
        rgb <= dot_on ? DOT_ON_RGB : DOT_OFF_RGB;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hdl/lcd_segment_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_segment_ram (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  wb_bus_pkg::wb_addr_t wb_adr,
  input  wb_bus_pkg::wb_data_t wb_dat_w,
  output wb_bus_pkg::wb_data_t wb_dat_r,
  output logic                 wb_ack,
  input  lcd_pkg::seg_addr_t   video_addr,
  output logic [3:0]           video_data,
  output logic                 lcd_all_off,
  output logic                 lcd_all_on
);

  import wb_bus_pkg::*;
  import lcd_pkg::*;

  logic [3:0] seg_mem [LCD_NIBBLES] = '{default: '0};

  wb_word_u wr_word;
  wb_word_u rd_word;
  logic     wb_req;
  logic     seg_sel;
  logic     ctrl_sel;

  // new request only, the ack cycle itself is not one.
  assign wb_req   = wb_cyc & wb_stb & ~wb_ack;
  assign seg_sel  = ~wb_adr[7];
  assign ctrl_sel = (wb_adr == WB_CTRL_ADDR);

  assign wr_word.raw = wb_dat_w;

  always_comb begin
    rd_word = '0;
    if (seg_sel) begin
      rd_word.seg.nibble = seg_mem[seg_addr_t'(wb_adr)];
    end else if (ctrl_sel) begin
      rd_word.ctrl.all_off = lcd_all_off;
      rd_word.ctrl.all_on  = lcd_all_on;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_ack      <= 1'b0;
      lcd_all_off <= 1'b0;
      lcd_all_on  <= 1'b0;
    end else begin
      wb_ack <= wb_req;
      if (wb_req && wb_we && ctrl_sel) begin
        lcd_all_off <= wr_word.ctrl.all_off;
        lcd_all_on  <= wr_word.ctrl.all_on;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req && wb_we && seg_sel) begin
      seg_mem[seg_addr_t'(wb_adr)] <= wr_word.seg.nibble;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_req && !wb_we) begin
      wb_dat_r <= rd_word.raw; // valid with ack.
    end
  end

  // scan-out port, independent of the bus.
  always_ff @(posedge clk) begin
    video_data <= seg_mem[video_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/program_rom.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_macros.svh"

module program_rom (
  input  logic        clk,
  input  logic [12:0] rom_addr,
  output logic [11:0] rom_data
);

  logic [11:0] rom_mem [`LCD_ROM_WORDS];

  initial begin
    $readmemh("rom_image.hex", rom_mem);
  end

  // one cycle read latency.
  always_ff @(posedge clk) begin
    rom_data <= rom_mem[rom_addr];
  end

endmodule

`default_nettype wire

// ==== hdl/tama_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tama_display_top (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  wb_bus_pkg::wb_addr_t wb_adr,
  input  wb_bus_pkg::wb_data_t wb_dat_w,
  output wb_bus_pkg::wb_data_t wb_dat_r,
  output logic                 wb_ack,
  input  logic [12:0]          rom_addr,
  output logic [11:0]          rom_data,
  output logic                 clk_en_slow,
  output logic                 clk_en_fast,
  output logic                 hsync,
  output logic                 vsync,
  output logic                 de,
  output lcd_pkg::rgb_t        rgb
);

  lcd_pkg::seg_addr_t video_addr;
  logic [3:0]         video_data;
  logic               lcd_all_off;
  logic               lcd_all_on;

  clk_enable_gen clk_enable_gen_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .clk_en_slow (clk_en_slow),
    .clk_en_fast (clk_en_fast)
  );

  program_rom program_rom_i (
    .clk      (clk),
    .rom_addr (rom_addr),
    .rom_data (rom_data)
  );

  lcd_segment_ram lcd_segment_ram_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .wb_cyc      (wb_cyc),
    .wb_stb      (wb_stb),
    .wb_we       (wb_we),
    .wb_adr      (wb_adr),
    .wb_dat_w    (wb_dat_w),
    .wb_dat_r    (wb_dat_r),
    .wb_ack      (wb_ack),
    .video_addr  (video_addr),
    .video_data  (video_data),
    .lcd_all_off (lcd_all_off),
    .lcd_all_on  (lcd_all_on)
  );

  lcd_scanout lcd_scanout_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .video_addr  (video_addr),
    .video_data  (video_data),
    .lcd_all_off (lcd_all_off),
    .lcd_all_on  (lcd_all_on),
    .hsync       (hsync),
    .vsync       (vsync),
    .de          (de),
    .rgb         (rgb)
  );

endmodule

`default_nettype wire

// ==== hdl/wb_bus_pkg.sv ====
`default_nettype none

package wb_bus_pkg;

  typedef logic [7:0] wb_addr_t; // word address.
  typedef logic [7:0] wb_data_t;

  localparam wb_addr_t WB_CTRL_ADDR = 8'h80;

  typedef struct packed {
    logic [3:0] unused;
    logic [3:0] nibble;
  } wb_seg_view_t;

  typedef struct packed {
    logic [5:0] reserved;
    logic       all_on;
    logic       all_off;
  } wb_ctrl_view_t;

  // one bus word, meaning depends on the address.
  typedef union packed {
    wb_data_t      raw;
    wb_seg_view_t  seg;
    wb_ctrl_view_t ctrl;
  } wb_word_u;

endpackage

`default_nettype wire

// ==== include/lcd_macros.svh ====
`ifndef LCD_MACROS_SVH
`define LCD_MACROS_SVH

// cpu strobe divider, one slow period is RELOAD + 1 clocks.
`define LCD_DIV_RELOAD 100
`define LCD_DIV_HALF   50

// horizontal timing in clocks.
`define LCD_H_ACTIVE 32
`define LCD_H_FRONT  4
`define LCD_H_SYNC   4
`define LCD_H_BACK   8
`define LCD_H_TOTAL  (`LCD_H_ACTIVE + `LCD_H_FRONT + `LCD_H_SYNC + `LCD_H_BACK)

// vertical timing in lines.
`define LCD_V_ACTIVE 16
`define LCD_V_FRONT  1
`define LCD_V_SYNC   1
`define LCD_V_BACK   2
`define LCD_V_TOTAL  (`LCD_V_ACTIVE + `LCD_V_FRONT + `LCD_V_SYNC + `LCD_V_BACK)

`define LCD_ROM_WORDS 8192

`endif

// ==== rom_image.hex ====
0e1
3a5
7f0
100
5c2
0ff
a3b
4d8
2e6
91c
b07
6a4
f3e
058
c91
8b2

// ==== verification/tama_display_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tama_display_checker (
  input logic clk,
  input logic arst_n,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic clk_en_slow,
  input logic clk_en_fast,
  input logic hsync,
  input logic de
);

  int unsigned fail_count = 0; // polled from the testbench.

  // classic ack is a single cycle pulse.
  ack_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |=> !wb_ack)
    else begin
      $error("wb_ack stayed high for two cycles");
      fail_count++;
    end

  ack_after_stb: assert property (@(posedge clk) disable iff (!arst_n)
    wb_ack |-> $past(wb_cyc && wb_stb))
    else begin
      $error("wb_ack without a preceding cyc and stb");
      fail_count++;
    end

  de_outside_hsync: assert property (@(posedge clk) disable iff (!arst_n)
    hsync |-> !de)
    else begin
      $error("de high during hsync");
      fail_count++;
    end

  slow_implies_fast: assert property (@(posedge clk) disable iff (!arst_n)
    clk_en_slow |-> clk_en_fast)
    else begin
      $error("clk_en_slow without clk_en_fast");
      fail_count++;
    end

endmodule

// one instance at the top sees the bus, the video and the enables.
bind tama_display_top tama_display_checker checker_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .wb_cyc      (wb_cyc),
  .wb_stb      (wb_stb),
  .wb_ack      (wb_ack),
  .clk_en_slow (clk_en_slow),
  .clk_en_fast (clk_en_fast),
  .hsync       (hsync),
  .de          (de)
);

`default_nettype wire

// ==== verification/tama_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lcd_macros.svh"

module tama_display_tb;

  import wb_bus_pkg::*;
  import lcd_pkg::*;

  localparam int FRAME_CYCLES = `LCD_H_TOTAL * `LCD_V_TOTAL;
  // three frame checks, each may first wait a frame for vsync. plus bus, rom, enables.
  localparam int CYCLE_LIMIT = 6 * FRAME_CYCLES + 240;
  localparam string PATTERN_FILE = "verification/tama_patterns.txt";

  logic        clk;
  logic        arst_n;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  wb_addr_t    wb_adr;
  wb_data_t    wb_dat_w;
  wb_data_t    wb_dat_r;
  logic        wb_ack;
  logic [12:0] rom_addr;
  logic [11:0] rom_data;
  logic        clk_en_slow;
  logic        clk_en_fast;
  logic        hsync;
  logic        vsync;
  logic        de;
  rgb_t        rgb;

  logic [3:0] seg_model [LCD_NIBBLES] = '{default: '0}; // segment memory model.
  logic       model_off = 1'b0;
  logic       model_on  = 1'b0;
  int         cycle_cnt = 0;

  tama_display_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("SIMULATION FAILED");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("MISMATCH %s expected 0x%0h actual 0x%0h", name, expected, actual);
      abort_run("a checked value was wrong");
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > CYCLE_LIMIT) begin
      abort_run("timeout, the run exceeded its cycle limit");
    end
    if (dut_i.checker_i.fail_count != 0) begin
      abort_run("an assertion in the bound checker failed");
    end
  end

  // dot (x, y) is bit x%4 of nibble y*8 + x/4.
  function automatic rgb_t expected_rgb(input int x, input int y);
    logic [3:0] nib;
    logic       dot;
    nib = seg_model[seg_addr_t'(y * (LCD_WIDTH / 4) + x / 4)];
    dot = model_off ? 1'b0 : (model_on | nib[2'(x)]);
    return dot ? DOT_ON_RGB : DOT_OFF_RGB;
  endfunction

  task automatic update_model(input logic [7:0] adr, input logic [7:0] dat);
    wb_word_u word;
    word.raw = dat;
    if (!adr[7]) begin
      seg_model[adr[6:0]] = word.seg.nibble;
    end else if (adr == WB_CTRL_ADDR) begin
      model_off = word.ctrl.all_off;
      model_on  = word.ctrl.all_on;
    end
  endtask

  task automatic bus_cycle(input logic we, input logic [7:0] adr, input logic [7:0] dat,
                           output logic [7:0] rdata);
    int waited;
    waited = 0;
    repeat ($urandom_range(2, 0)) @(posedge clk); // random idle gap.
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    @(negedge clk);
    while (!wb_ack) begin
      waited++;
      if (waited > 8) begin
        abort_run("no ack from the segment memory");
      end
      @(negedge clk);
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic rom_read(input logic [12:0] addr, output logic [11:0] data);
    @(posedge clk);
    rom_addr <= addr;
    @(posedge clk); // rom registers here.
    @(negedge clk);
    data = rom_data;
  endtask

  task automatic check_enables();
    int gap;
    int fast_cnt;
    @(negedge clk);
    while (!clk_en_slow) @(negedge clk);
    repeat (2) begin
      gap      = 0;
      fast_cnt = 0;
      do begin
        @(negedge clk);
        gap++;
        if (clk_en_fast) fast_cnt++;
      end while (!clk_en_slow);
      check_value("slow enable period", 32'(`LCD_DIV_RELOAD + 1), 32'(gap));
      check_value("fast enables per period", 32'd2, 32'(fast_cnt));
    end
  endtask

  task automatic check_frame(input string name, input logic [31:0] exp_de);
    int k;
    int hs_cnt;
    @(negedge clk);
    while (!vsync) @(negedge clk);
    while (vsync) @(negedge clk); // first cycle after the falling edge.
    k      = 0;
    hs_cnt = 0;
    while (!vsync) begin
      if (hsync) hs_cnt++;
      if (de) begin
        check_value(name, 32'(expected_rgb(k % LCD_WIDTH, k / LCD_WIDTH)), 32'(rgb));
        k++;
      end else begin
        check_value({name, " blank"}, 32'h0, 32'(rgb));
      end
      @(negedge clk);
    end
    check_value({name, " de count"}, exp_de, 32'(k));
    // one full hsync pulse on every line but the vsync line.
    check_value({name, " hsync count"},
                32'((`LCD_V_TOTAL - `LCD_V_SYNC) * `LCD_H_SYNC), 32'(hs_cnt));
  endtask

  task automatic run_patterns();
    int          fd;
    int          line_no;
    int          fields;
    string       line;
    string       name;
    logic [7:0]  kind;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp_val;
    logic [7:0]  rdata;
    logic [11:0] rom_val;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the pattern file");
    end
    line_no = 0;
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      fields = $sscanf(line, "%c %h %h %h", kind, adr, dat, exp_val);
      if (fields != 4) begin
        abort_run($sformatf("malformed pattern line %0d", line_no));
      end
      name = $sformatf("line %0d %c %02h", line_no, kind, adr[7:0]);
      case (kind)
        "W": begin
          bus_cycle(1'b1, adr[7:0], dat[7:0], rdata);
          update_model(adr[7:0], dat[7:0]);
        end
        "R": begin
          bus_cycle(1'b0, adr[7:0], 8'h00, rdata);
          check_value(name, exp_val, 32'(rdata));
        end
        "M": begin
          rom_read(adr[12:0], rom_val);
          check_value(name, exp_val, 32'(rom_val));
        end
        "F": check_frame(name, exp_val);
        default: abort_run($sformatf("unknown operation on pattern line %0d", line_no));
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    void'($urandom(32'hd16ceb54));
    arst_n   = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    rom_addr = '0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    check_enables();
    run_patterns();
    repeat (2) @(posedge clk);
    if (dut_i.checker_i.fail_count != 0) begin
      abort_run("an assertion in the bound checker failed");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verification/tama_patterns.txt ====
# kind addr data expected, all hex. F expects the de cycles per frame.
# W bus write, R bus read, M rom read, F frame check.
W 00 0f 0
W 05 a5 0
W 13 3c 0
W 2a 09 0
W 4e f6 0
W 61 72 0
W 7f 81 0
R 05 00 05
R 13 00 0c
R 7f 00 01
R 00 00 0f
R 4e 00 06
R 61 00 02
R 81 00 00
R c4 00 00
R ff 00 00
M 0000 000 0e1
M 0003 000 100
M 0007 000 4d8
M 000c 000 f3e
M 000f 000 8b2
W 80 fd 0
R 80 00 01
F 00 00 200
W 80 02 0
R 80 00 02
F 00 00 200
W 80 00 0
R 80 00 00
F 00 00 200
